//--- files.f
+incdir+dv
rtl/dispatchTypes.sv
rtl/queueOccupancy.sv
rtl/issueQueuePayload.sv
rtl/dispatchStage.sv
rtl/dispatchController.sv
rtl/dispatchTop.sv
dv/dispatchTb.sv

//--- dv/dispatchVectors.svh
// Dispatch test table
// Ops, releases and flushes with the expected slot, stall and queue counts
`ifndef dispatchVectorsSvh
`define dispatchVectorsSvh

// Each row holds name, action, class (or queue to release), sub-type, operand types A and B,
// 12-bit operand, load and store queue pointer, then expected stall, write check,
// slot, integer count, complex count and memory count
localparam int numRows = 14;

localparam vectorT vectors [numRows] = '{
    // Operand padding bits set that must not reach the entry
    '{"intAlu", ActIssue, dispatchTypes::OpInt, 2'd0,
      dispatchTypes::OperandReg, dispatchTypes::OperandImm, 12'hf35, 3'd0, 3'd0,
      1'b0, 1'b1, 2'd0, 3'd1, 3'd0, 3'd0},
    '{"intBranch", ActIssue, dispatchTypes::OpInt, 2'd2,
      dispatchTypes::OperandReg, dispatchTypes::OperandReg, 12'h0a7, 3'd0, 3'd0,
      1'b0, 1'b1, 2'd1, 3'd2, 3'd0, 3'd0},
    '{"complexMul", ActIssue, dispatchTypes::OpComplex, 2'd0,
      dispatchTypes::OperandReg, dispatchTypes::OperandReg, 12'h01c, 3'd0, 3'd0,
      1'b0, 1'b1, 2'd0, 3'd2, 3'd1, 3'd0},
    '{"complexDiv", ActIssue, dispatchTypes::OpComplex, 2'd1,
      dispatchTypes::OperandReg, dispatchTypes::OperandZero, 12'h002, 3'd0, 3'd0,
      1'b0, 1'b1, 2'd1, 3'd2, 3'd2, 3'd0},
    '{"memLoad", ActIssue, dispatchTypes::OpMem, 2'd0,
      dispatchTypes::OperandReg, dispatchTypes::OperandImm, 12'h002, 3'd5, 3'd2,
      1'b0, 1'b1, 2'd0, 3'd2, 3'd2, 3'd1},
    '{"memStore", ActIssue, dispatchTypes::OpMem, 2'd1,
      dispatchTypes::OperandReg, dispatchTypes::OperandReg, 12'h003, 3'd6, 3'd3,
      1'b0, 1'b1, 2'd1, 3'd2, 3'd2, 3'd2},
    '{"memRelease", ActRelease, dispatchTypes::OpMem, 2'd0,
      dispatchTypes::OperandReg, dispatchTypes::OperandReg, 12'h000, 3'd0, 3'd0,
      1'b0, 1'b0, 2'd0, 3'd2, 3'd2, 3'd1},
    '{"intShift", ActIssue, dispatchTypes::OpInt, 2'd1,
      dispatchTypes::OperandReg, dispatchTypes::OperandPc, 12'h02a, 3'd0, 3'd0,
      1'b0, 1'b1, 2'd2, 3'd3, 3'd2, 3'd1},
    '{"intJumpReg", ActIssue, dispatchTypes::OpInt, 2'd3,
      dispatchTypes::OperandReg, dispatchTypes::OperandImm, 12'h014, 3'd0, 3'd0,
      1'b0, 1'b1, 2'd3, 3'd4, 3'd2, 3'd1},
    // Integer queue full so the op stays in the stage
    '{"intFullStall", ActIssue, dispatchTypes::OpInt, 2'd0,
      dispatchTypes::OperandImm, dispatchTypes::OperandReg, 12'h009, 3'd0, 3'd0,
      1'b1, 1'b0, 2'd0, 3'd4, 3'd2, 3'd1},
    '{"intRelease", ActRelease, dispatchTypes::OpInt, 2'd0,
      dispatchTypes::OperandReg, dispatchTypes::OperandReg, 12'h000, 3'd0, 3'd0,
      1'b0, 1'b1, 2'd0, 3'd4, 3'd2, 3'd1},
    // Stall high in the flushing cycle, slot is the memory tail the flushed op aimed at
    '{"flushMem", ActFlush, dispatchTypes::OpMem, 2'd0,
      dispatchTypes::OperandReg, dispatchTypes::OperandImm, 12'h001, 3'd4, 3'd1,
      1'b1, 1'b0, 2'd2, 3'd0, 3'd0, 3'd0},
    '{"afterFlush", ActIssue, dispatchTypes::OpInt, 2'd0,
      dispatchTypes::OperandZero, dispatchTypes::OperandReg, 12'h07b, 3'd0, 3'd0,
      1'b0, 1'b1, 2'd0, 3'd1, 3'd0, 3'd0},
    '{"idle", ActIdle, dispatchTypes::OpInt, 2'd0,
      dispatchTypes::OperandReg, dispatchTypes::OperandReg, 12'h000, 3'd0, 3'd0,
      1'b0, 1'b0, 2'd0, 3'd1, 3'd0, 3'd0}
};

`endif

//--- dv/dispatchTb.sv
// Dispatch subsystem testbench
// Steps a table of ops, releases and flushes through the dispatch top level
// and checks queue entries, counts and the stall level
`timescale 1ns/100ps
`default_nettype none

module dispatchTb;

    localparam int depth       = 4;
    localparam int clockPeriod = 40;

    typedef enum logic [1:0] {ActIssue, ActRelease, ActFlush, ActIdle} actionT;

    // One table row with stimulus first and expected values after
    typedef struct packed {
        logic [8*12-1:0]            name;
        actionT                     action;
        dispatchTypes::opClassT     opClass;
        logic [1:0]                 subType;
        dispatchTypes::operandTypeT typeA;
        dispatchTypes::operandTypeT typeB;
        logic [11:0]                operand;
        dispatchTypes::lsqPtrT      loadPtr;
        dispatchTypes::lsqPtrT      storePtr;
        logic                       expStall;
        logic                       checkWrite;
        logic [1:0]                 expSlot;
        logic [2:0]                 expIntCount;
        logic [2:0]                 expComplexCount;
        logic [2:0]                 expMemCount;
    } vectorT;

    `include "dispatchVectors.svh"

    logic                        ctrl;
    logic                        arstN;
    logic                        opValid;
    dispatchTypes::renamedOpT    opIn;
    logic                        dispatchStall;
    logic                        flush;
    logic                        intRelease;
    logic                        complexRelease;
    logic                        memRelease;
    logic [1:0]                  intReadPtr;
    logic [1:0]                  complexReadPtr;
    logic [1:0]                  memReadPtr;
    dispatchTypes::intEntryT     intReadData;
    dispatchTypes::complexEntryT complexReadData;
    dispatchTypes::memEntryT     memReadData;
    logic [2:0]                  intCount;
    logic [2:0]                  complexCount;
    logic [2:0]                  memCount;

    int                          seed = 32'hf90f4b56;
    int                          errorCount = 0;
    int                          checkCount = 0;
    dispatchTypes::renamedOpT    lastOp;

    dispatchTop #(.depth(depth)) dut (
        .ctrl, .arstN, .opValid, .opIn, .dispatchStall, .flush,
        .intRelease, .complexRelease, .memRelease,
        .intReadPtr, .complexReadPtr, .memReadPtr,
        .intReadData, .complexReadData, .memReadData,
        .intCount, .complexCount, .memCount
    );

    always #(clockPeriod / 2) ctrl = ~ctrl;

    task automatic compareValue(input string testName, input logic [63:0] expected,
                                input logic [63:0] actual);
        checkCount++;
        if (actual !== expected) begin
            errorCount++;
            $display("[ERROR] %s expected %0h actual %0h", testName, expected, actual);
        end
    endtask

    // Table fields plus random registers, pc and active list pointer
    function automatic dispatchTypes::renamedOpT makeOp(input vectorT row);
        dispatchTypes::renamedOpT op;
        logic [31:0]              rnd;
        op               = '0;
        op.opClass       = row.opClass;
        op.subType       = row.subType;
        op.operandTypeA  = row.typeA;
        op.operandTypeB  = row.typeB;
        op.operand       = row.operand;
        op.loadQueuePtr  = row.loadPtr;
        op.storeQueuePtr = row.storePtr;
        rnd              = $random(seed);
        op.pc            = rnd[15:0];
        op.physSrcA      = rnd[21:16];
        op.physSrcB      = rnd[27:22];
        rnd              = $random(seed);
        op.physDst       = rnd[5:0];
        op.activeListPtr = rnd[10:6];
        op.writeReg      = rnd[11];
        op.brPred        = rnd[12];
        return op;
    endfunction

    function automatic dispatchTypes::commonEntryT expectedCommon(
        input dispatchTypes::renamedOpT op);
        dispatchTypes::commonEntryT c;
        c.physSrcA      = op.physSrcA;
        c.physSrcB      = op.physSrcB;
        c.physDst       = op.physDst;
        c.writeReg      = op.writeReg;
        // Only register operands wait for a source
        c.srcNeededA    = (op.operandTypeA == dispatchTypes::OperandReg);
        c.srcNeededB    = (op.operandTypeB == dispatchTypes::OperandReg);
        c.activeListPtr = op.activeListPtr;
        c.pc            = op.pc;
        return c;
    endfunction

    task automatic checkQueueEntry(input string testName, input dispatchTypes::renamedOpT op);
        dispatchTypes::commonEntryT common;
        logic [11:0]                intInfo;
        logic [2:0]                 complexInfo;
        dispatchTypes::lsqPtrT      lsqPtr;
        common = expectedCommon(op);
        case (op.opClass)
            dispatchTypes::OpInt: begin
                if ((op.subType == dispatchTypes::IntBranch) ||
                    (op.subType == dispatchTypes::IntJumpReg)) begin
                    intInfo = {op.operand.brOp.brDisp, op.operandTypeA, op.operandTypeB};
                end else begin
                    intInfo = {op.operand.intOp.aluCode, op.operand.intOp.shiftType,
                               op.operandTypeA, op.operandTypeB, 2'b00};
                end
                compareValue({testName, ".common"}, 64'(common), 64'(intReadData.common));
                compareValue({testName, ".type"}, 64'(op.subType), 64'(intReadData.intType));
                compareValue({testName, ".info"}, 64'(intInfo), 64'(intReadData.intOpInfo));
            end
            dispatchTypes::OpComplex: begin
                if (op.subType[0] == dispatchTypes::ComplexMul) begin
                    complexInfo = {op.operand.complexOp.mulGetUpper, op.operand.complexOp.mulCode};
                end else begin
                    complexInfo = {op.operand.complexOp.divCode, 1'b0};
                end
                compareValue({testName, ".common"}, 64'(common), 64'(complexReadData.common));
                compareValue({testName, ".type"}, 64'(op.subType[0]),
                             64'(complexReadData.complexType));
                compareValue({testName, ".info"}, 64'(complexInfo),
                             64'(complexReadData.complexOpInfo));
            end
            default: begin
                lsqPtr = (op.subType[0] == dispatchTypes::MemLoad) ? op.loadQueuePtr
                                                                   : op.storeQueuePtr;
                compareValue({testName, ".common"}, 64'(common), 64'(memReadData.common));
                compareValue({testName, ".type"}, 64'(op.subType[0]), 64'(memReadData.memType));
                compareValue({testName, ".size"}, 64'(op.operand.memOp.accessSize),
                             64'(memReadData.accessSize));
                compareValue({testName, ".lsqPtr"}, 64'(lsqPtr), 64'(memReadData.lsqPtr));
                compareValue({testName, ".ldRecovery"}, 64'(op.loadQueuePtr),
                             64'(memReadData.loadQueueRecoveryPtr));
                compareValue({testName, ".stRecovery"}, 64'(op.storeQueuePtr),
                             64'(memReadData.storeQueueRecoveryPtr));
            end
        endcase
    endtask

    // Returns at the clock edge that takes the op
    task automatic waitForAccept();
        do begin
            @(negedge ctrl);
        end while (dispatchStall);
        @(posedge ctrl);
    endtask

    // Returns at the clock edge that writes the held op and aims the read ports at its slot
    task automatic waitForWrite(input logic [1:0] slot);
        do begin
            @(negedge ctrl);
        end while (dispatchStall);
        @(posedge ctrl);
        intReadPtr     <= slot;
        complexReadPtr <= slot;
        memReadPtr     <= slot;
    endtask

    task automatic runRow(input vectorT row);
        string testName;
        testName = string'(row.name);
        @(posedge ctrl);
        case (row.action)
            ActIssue, ActFlush: begin
                lastOp = makeOp(row);
                opValid <= 1'b1;
                opIn    <= lastOp;
                waitForAccept();
                opValid <= 1'b0;
                if (row.action == ActFlush) begin
                    flush <= 1'b1;
                    @(posedge ctrl);
                    flush      <= 1'b0;
                    memReadPtr <= row.expSlot;
                end
            end
            ActRelease: begin
                intRelease     <= (row.opClass == dispatchTypes::OpInt);
                complexRelease <= (row.opClass == dispatchTypes::OpComplex);
                memRelease     <= (row.opClass == dispatchTypes::OpMem);
                @(posedge ctrl);
                intRelease     <= 1'b0;
                complexRelease <= 1'b0;
                memRelease     <= 1'b0;
            end
            default: begin
            end
        endcase
        if (row.checkWrite) begin
            waitForWrite(row.expSlot);
            @(negedge ctrl);
            checkQueueEntry(testName, lastOp);
        end else begin
            @(negedge ctrl);
        end
        compareValue({testName, ".stall"}, 64'(row.expStall), 64'(dispatchStall));
        compareValue({testName, ".intCount"}, 64'(row.expIntCount), 64'(intCount));
        compareValue({testName, ".complexCount"}, 64'(row.expComplexCount), 64'(complexCount));
        compareValue({testName, ".memCount"}, 64'(row.expMemCount), 64'(memCount));
        if (row.action == ActFlush) begin
            // One flushing cycle and then running again with nothing written
            @(negedge ctrl);
            compareValue({testName, ".resume"}, 64'd0, 64'(dispatchStall));
            compareValue({testName, ".memCount"}, 64'd0, 64'(memCount));
            // The flushed op must not appear at the slot it was aimed at
            compareValue({testName, ".suppressed"}, 64'd0,
                         64'(memReadData.common === expectedCommon(lastOp)));
        end
    endtask

    initial begin
        #(numRows * 10 * clockPeriod);
        $display("Timeout: the run did not finish within %0d ns", numRows * 10 * clockPeriod);
        $display("test failed");
        $finish;
    end

    initial begin
        ctrl           = 1'b0;
        arstN          = 1'b0;
        opValid        = 1'b0;
        opIn           = '0;
        flush          = 1'b0;
        intRelease     = 1'b0;
        complexRelease = 1'b0;
        memRelease     = 1'b0;
        intReadPtr     = '0;
        complexReadPtr = '0;
        memReadPtr     = '0;
        lastOp         = '0;
        repeat (5) @(posedge ctrl);
        arstN <= 1'b1;
        @(negedge ctrl);
        compareValue("reset.stall", 64'd0, 64'(dispatchStall));
        compareValue("reset.intCount", 64'd0, 64'(intCount));
        compareValue("reset.complexCount", 64'd0, 64'(complexCount));
        compareValue("reset.memCount", 64'd0, 64'(memCount));
        for (int i = 0; i < numRows; i++) begin
            runRow(vectors[i]);
        end
        $display("Summary: %0d checks, %0d errors", checkCount, errorCount);
        if (errorCount == 0) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- rtl/dispatchTop.sv
// Dispatch subsystem top level
// Dispatch stage, control FSM and three issue queues
// with occupancy counters and payload RAMs
`timescale 1ns/100ps
`default_nettype none

module dispatchTop #(
    parameter int depth = dispatchTypes::queueDepth
) (
    input  logic                        ctrl,
    input  logic                        arstN,
    // Rename side
    input  logic                        opValid,
    input  dispatchTypes::renamedOpT    opIn,
    output logic                        dispatchStall,
    input  logic                        flush,
    // Issue side
    input  logic                        intRelease,
    input  logic                        complexRelease,
    input  logic                        memRelease,
    input  logic [$clog2(depth)-1:0]    intReadPtr,
    input  logic [$clog2(depth)-1:0]    complexReadPtr,
    input  logic [$clog2(depth)-1:0]    memReadPtr,
    output dispatchTypes::intEntryT     intReadData,
    output dispatchTypes::complexEntryT complexReadData,
    output dispatchTypes::memEntryT     memReadData,
    output logic [$clog2(depth+1)-1:0]  intCount,
    output logic [$clog2(depth+1)-1:0]  complexCount,
    output logic [$clog2(depth+1)-1:0]  memCount
);

    logic                        heldValid;
    dispatchTypes::opClassT      heldClass;
    logic                        intWrite;
    logic                        complexWrite;
    logic                        memWrite;
    dispatchTypes::intEntryT     intEntry;
    dispatchTypes::complexEntryT complexEntry;
    dispatchTypes::memEntryT     memEntry;
    logic                        stageStall;
    logic                        stageClear;
    logic                        counterClear;
    logic [$clog2(depth)-1:0]    intTail;
    logic [$clog2(depth)-1:0]    complexTail;
    logic [$clog2(depth)-1:0]    memTail;
    logic                        intFull;
    logic                        complexFull;
    logic                        memFull;

    assign dispatchStall = stageStall;

    dispatchStage stage (
        .ctrl, .arstN, .opValid, .opIn, .stageStall, .stageClear,
        .heldValid, .heldClass, .intWrite, .complexWrite, .memWrite,
        .intEntry, .complexEntry, .memEntry
    );

    dispatchController controller (
        .ctrl, .arstN, .flush, .heldValid, .heldClass,
        .intFull, .complexFull, .memFull,
        .stageStall, .stageClear, .counterClear
    );

    // Integer queue
    queueOccupancy #(.depth(depth)) intOccupancy (
        .ctrl, .arstN, .write(intWrite), .releaseHead(intRelease),
        .clear(counterClear), .tail(intTail), .count(intCount), .full(intFull)
    );

    issueQueuePayload #(.depth(depth), .entryT(dispatchTypes::intEntryT)) intPayload (
        .ctrl, .write(intWrite), .writePtr(intTail), .writeData(intEntry),
        .readPtr(intReadPtr), .readData(intReadData)
    );

    // Complex queue
    queueOccupancy #(.depth(depth)) complexOccupancy (
        .ctrl, .arstN, .write(complexWrite), .releaseHead(complexRelease),
        .clear(counterClear), .tail(complexTail), .count(complexCount),
        .full(complexFull)
    );

    issueQueuePayload #(.depth(depth), .entryT(dispatchTypes::complexEntryT)) complexPayload (
        .ctrl, .write(complexWrite), .writePtr(complexTail), .writeData(complexEntry),
        .readPtr(complexReadPtr), .readData(complexReadData)
    );

    // Memory queue
    queueOccupancy #(.depth(depth)) memOccupancy (
        .ctrl, .arstN, .write(memWrite), .releaseHead(memRelease),
        .clear(counterClear), .tail(memTail), .count(memCount), .full(memFull)
    );

    issueQueuePayload #(.depth(depth), .entryT(dispatchTypes::memEntryT)) memPayload (
        .ctrl, .write(memWrite), .writePtr(memTail), .writeData(memEntry),
        .readPtr(memReadPtr), .readData(memReadData)
    );

endmodule

`default_nettype wire

//--- rtl/dispatchController.sv
// Dispatch control FSM
// Stalls on a full target queue, clears the stage and counters on flush
`timescale 1ns/100ps
`default_nettype none

module dispatchController (
    input  logic                   ctrl,
    input  logic                   arstN,
    input  logic                   flush,
    input  logic                   heldValid,
    input  dispatchTypes::opClassT heldClass,
    input  logic                   intFull,
    input  logic                   complexFull,
    input  logic                   memFull,
    output logic                   stageStall,
    output logic                   stageClear,
    output logic                   counterClear
);

    typedef enum logic [1:0] {Running, Blocked, Flushing} stateT;

    stateT state;
    stateT nextState;
    logic  targetFull;
    logic  heldBlocked;

    always_comb begin
        case (heldClass)
            dispatchTypes::OpInt:     targetFull = intFull;
            dispatchTypes::OpComplex: targetFull = complexFull;
            dispatchTypes::OpMem:     targetFull = memFull;
            default:                  targetFull = 1'b0;
        endcase
    end

    assign heldBlocked = heldValid && targetFull;

    always_comb begin
        nextState = state;
        if (flush) begin
            nextState = Flushing;
        end else begin
            case (state)
                Running:  nextState = heldBlocked ? Blocked : Running;
                Blocked:  nextState = heldBlocked ? Blocked : Running;
                // Stage is empty after a flush
                Flushing: nextState = Running;
                default:  nextState = Running;
            endcase
        end
    end

    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            state <= Running;
        end else begin
            state <= nextState;
        end
    end

    // Stall follows a full target queue in the same cycle
    assign stageStall   = (state == Flushing) || heldBlocked;
    assign stageClear   = flush || (state == Flushing);
    assign counterClear = flush || (state == Flushing);

endmodule

`default_nettype wire

//--- rtl/dispatchStage.sv
// Dispatch stage
// Pipeline register for one renamed op, formatted into an entry
// for the integer, complex or memory issue queue
`timescale 1ns/100ps
`default_nettype none

module dispatchStage (
    input  logic                        ctrl,
    input  logic                        arstN,
    input  logic                        opValid,
    input  dispatchTypes::renamedOpT    opIn,
    input  logic                        stageStall,
    input  logic                        stageClear,
    output logic                        heldValid,
    output dispatchTypes::opClassT      heldClass,
    output logic                        intWrite,
    output logic                        complexWrite,
    output logic                        memWrite,
    output dispatchTypes::intEntryT     intEntry,
    output dispatchTypes::complexEntryT complexEntry,
    output dispatchTypes::memEntryT     memEntry
);

    dispatchTypes::renamedOpT    heldOp;
    dispatchTypes::commonEntryT  common;
    dispatchTypes::intSubInfoT   intSubInfo;
    dispatchTypes::brSubInfoT    brSubInfo;
    dispatchTypes::mulSubInfoT   mulSubInfo;
    dispatchTypes::divSubInfoT   divSubInfo;
    logic                        update;

    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            heldValid <= 1'b0;
        end else if (stageClear) begin
            heldValid <= 1'b0;
        end else if (!stageStall) begin
            heldValid <= opValid;
        end
    end

    // Op payload register
    always_ff @(posedge ctrl) begin
        if (!stageStall) begin
            heldOp <= opIn;
        end
    end

    assign heldClass = heldOp.opClass;
    assign update = heldValid && !stageStall && !stageClear;

    assign intWrite     = update && (heldOp.opClass == dispatchTypes::OpInt);
    assign complexWrite = update && (heldOp.opClass == dispatchTypes::OpComplex);
    assign memWrite     = update && (heldOp.opClass == dispatchTypes::OpMem);

    always_comb begin
        common.physSrcA      = heldOp.physSrcA;
        common.physSrcB      = heldOp.physSrcB;
        common.physDst       = heldOp.physDst;
        common.writeReg      = heldOp.writeReg;
        // Only register operands wait on a producer
        common.srcNeededA    = (heldOp.operandTypeA == dispatchTypes::OperandReg);
        common.srcNeededB    = (heldOp.operandTypeB == dispatchTypes::OperandReg);
        common.activeListPtr = heldOp.activeListPtr;
        common.pc            = heldOp.pc;

        // Integer queue
        intSubInfo.aluCode      = heldOp.operand.intOp.aluCode;
        intSubInfo.shiftType    = heldOp.operand.intOp.shiftType;
        intSubInfo.operandTypeA = heldOp.operandTypeA;
        intSubInfo.operandTypeB = heldOp.operandTypeB;
        intSubInfo.padding      = '0;

        brSubInfo.brDisp       = heldOp.operand.brOp.brDisp;
        brSubInfo.operandTypeA = heldOp.operandTypeA;
        brSubInfo.operandTypeB = heldOp.operandTypeB;

        intEntry.common  = common;
        intEntry.intType = dispatchTypes::intOpT'(heldOp.subType);
        if ((intEntry.intType == dispatchTypes::IntBranch) ||
            (intEntry.intType == dispatchTypes::IntJumpReg)) begin
            intEntry.intOpInfo.brSubInfo = brSubInfo;
        end else begin
            intEntry.intOpInfo.intSubInfo = intSubInfo;
        end

        // Complex queue
        mulSubInfo.mulGetUpper = heldOp.operand.complexOp.mulGetUpper;
        mulSubInfo.mulCode     = heldOp.operand.complexOp.mulCode;
        divSubInfo.divCode     = heldOp.operand.complexOp.divCode;
        divSubInfo.padding     = 1'b0;

        complexEntry.common      = common;
        complexEntry.complexType = dispatchTypes::complexOpT'(heldOp.subType[0]);
        if (complexEntry.complexType == dispatchTypes::ComplexMul) begin
            complexEntry.complexOpInfo.mulSubInfo = mulSubInfo;
        end else begin
            complexEntry.complexOpInfo.divSubInfo = divSubInfo;
        end

        // Memory queue
        memEntry.common     = common;
        memEntry.memType    = dispatchTypes::memOpT'(heldOp.subType[0]);
        memEntry.accessSize = heldOp.operand.memOp.accessSize;
        if (memEntry.memType == dispatchTypes::MemLoad) begin
            memEntry.lsqPtr = heldOp.loadQueuePtr;
        end else begin
            memEntry.lsqPtr = heldOp.storeQueuePtr;
        end
        // LSQ tails at dispatch kept for recovery
        memEntry.loadQueueRecoveryPtr  = heldOp.loadQueuePtr;
        memEntry.storeQueueRecoveryPtr = heldOp.storeQueuePtr;
    end

endmodule

`default_nettype wire

//--- rtl/issueQueuePayload.sv
// Issue queue payload RAM
// One write port by strobe, one asynchronous read port
`timescale 1ns/100ps
`default_nettype none

module issueQueuePayload #(
    parameter int  depth  = dispatchTypes::queueDepth,
    parameter type entryT = dispatchTypes::intEntryT
) (
    input  logic                     ctrl,
    input  logic                     write,
    input  logic [$clog2(depth)-1:0] writePtr,
    input  entryT                    writeData,
    input  logic [$clog2(depth)-1:0] readPtr,
    output entryT                    readData
);

    entryT mem [depth];

    // One entry per write strobe at the tail slot
    always_ff @(posedge ctrl) begin
        if (write) begin
            mem[writePtr] <= writeData;
        end
    end

    assign readData = mem[readPtr];

endmodule

`default_nettype wire

//--- rtl/queueOccupancy.sv
// Issue queue occupancy
// Wrapping head and tail pointers, count derived from them, full flag
`timescale 1ns/100ps
`default_nettype none

module queueOccupancy #(
    parameter int depth = dispatchTypes::queueDepth
) (
    input  logic                       ctrl,
    input  logic                       arstN,
    input  logic                       write,
    input  logic                       releaseHead,
    input  logic                       clear,
    output logic [$clog2(depth)-1:0]   tail,
    output logic [$clog2(depth+1)-1:0] count,
    output logic                       full
);

    localparam int ptrWidth   = $clog2(depth);
    localparam int countWidth = $clog2(depth + 1);

    logic [ptrWidth-1:0] head;
    logic                headWrap;
    logic                tailWrap;
    logic                doWrite;
    logic                doRelease;

    // Tail behind head once it has wrapped one more time
    always_comb begin
        if (headWrap == tailWrap) begin
            count = countWidth'(tail) - countWidth'(head);
        end else begin
            count = countWidth'(depth) - countWidth'(head) + countWidth'(tail);
        end
    end

    assign full      = (count == countWidth'(depth));
    assign doWrite   = write && !full;
    assign doRelease = releaseHead && (count != '0);

    always_ff @(posedge ctrl or negedge arstN) begin
        if (!arstN) begin
            head     <= '0;
            tail     <= '0;
            headWrap <= 1'b0;
            tailWrap <= 1'b0;
        end else if (clear) begin
            head     <= '0;
            tail     <= '0;
            headWrap <= 1'b0;
            tailWrap <= 1'b0;
        end else begin
            if (doWrite) begin
                if (tail == ptrWidth'(depth - 1)) begin
                    tail     <= '0;
                    tailWrap <= !tailWrap;
                end else begin
                    tail <= tail + 1'b1;
                end
            end
            if (doRelease) begin
                if (head == ptrWidth'(depth - 1)) begin
                    head     <= '0;
                    headWrap <= !headWrap;
                end else begin
                    head <= head + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

//--- rtl/dispatchTypes.sv
// Dispatch type definitions
// Op classes, operand types, sub-info layouts and issue queue entries
`default_nettype none

package dispatchTypes;

    localparam int queueDepth = 8;

    typedef logic [5:0] physRegT;
    typedef logic [4:0] activeListPtrT;
    typedef logic [2:0] lsqPtrT;

    // Target queue of an op
    typedef enum logic [1:0] {OpInt, OpComplex, OpMem} opClassT;

    typedef enum logic [1:0] {IntAlu, IntShift, IntBranch, IntJumpReg} intOpT;
    typedef enum logic {ComplexMul, ComplexDiv} complexOpT;
    typedef enum logic {MemLoad, MemStore} memOpT;
    typedef enum logic [1:0] {OperandReg, OperandImm, OperandPc, OperandZero} operandTypeT;

    // 12-bit operand field from rename with one view per class
    typedef struct packed {
        logic [5:0] padding;
        logic [1:0] shiftType;
        logic [3:0] aluCode;
    } intOperandT;

    typedef struct packed {
        logic [3:0] padding;
        logic [7:0] brDisp;
    } brOperandT;

    typedef struct packed {
        logic [6:0] padding;
        logic       mulGetUpper;
        logic [1:0] mulCode;
        logic [1:0] divCode;
    } complexOperandT;

    typedef struct packed {
        logic [9:0] padding;
        logic [1:0] accessSize;
    } memOperandT;

    typedef union packed {
        intOperandT     intOp;
        brOperandT      brOp;
        complexOperandT complexOp;
        memOperandT     memOp;
    } operandT;

    // Integer sub-info is padded up to the branch width
    typedef struct packed {
        logic [3:0]  aluCode;
        logic [1:0]  shiftType;
        operandTypeT operandTypeA;
        operandTypeT operandTypeB;
        logic [1:0]  padding;
    } intSubInfoT;

    typedef struct packed {
        logic [7:0]  brDisp;
        operandTypeT operandTypeA;
        operandTypeT operandTypeB;
    } brSubInfoT;

    typedef struct packed {
        logic       mulGetUpper;
        logic [1:0] mulCode;
    } mulSubInfoT;

    typedef struct packed {
        logic [1:0] divCode;
        logic       padding;
    } divSubInfoT;

    typedef union packed {
        intSubInfoT intSubInfo;
        brSubInfoT  brSubInfo;
    } intOpInfoT;

    typedef union packed {
        mulSubInfoT mulSubInfo;
        divSubInfoT divSubInfo;
    } complexOpInfoT;

    // Sub-type read as intOpT or bit 0 as complexOpT or memOpT
    typedef struct packed {
        opClassT       opClass;
        logic [1:0]    subType;
        operandTypeT   operandTypeA;
        operandTypeT   operandTypeB;
        operandT       operand;
        logic          writeReg;
        physRegT       physSrcA;
        physRegT       physSrcB;
        physRegT       physDst;
        activeListPtrT activeListPtr;
        lsqPtrT        loadQueuePtr;
        lsqPtrT        storeQueuePtr;
        logic [15:0]   pc;
        logic          brPred;
    } renamedOpT;

    // Fields every queue entry carries
    typedef struct packed {
        physRegT       physSrcA;
        physRegT       physSrcB;
        physRegT       physDst;
        logic          writeReg;
        logic          srcNeededA;
        logic          srcNeededB;
        activeListPtrT activeListPtr;
        logic [15:0]   pc;
    } commonEntryT;

    typedef struct packed {
        commonEntryT common;
        intOpT       intType;
        intOpInfoT   intOpInfo;
    } intEntryT;

    typedef struct packed {
        commonEntryT   common;
        complexOpT     complexType;
        complexOpInfoT complexOpInfo;
    } complexEntryT;

    typedef struct packed {
        commonEntryT common;
        memOpT       memType;
        logic [1:0]  accessSize;
        lsqPtrT      lsqPtr;
        lsqPtrT      loadQueueRecoveryPtr;
        lsqPtrT      storeQueueRecoveryPtr;
    } memEntryT;

endpackage

`default_nettype wire
